//--- dv/gpu_core_assertions.sv
// bound checks of gpu core usage rules, result_valid timing and write-back strobes
`default_nettype none

module gpu_core_assertions (
	input logic sys_clk,
	input logic rst_n,
	input logic instr_valid,
	input logic host_en,
	input logic result_valid,
	input logic wb_en,
	input logic wb_nwe
);

	// caller keeps the gap while a result is shown
	a_gap_kept: assert property (@(posedge sys_clk) disable iff (!rst_n)
		result_valid |-> (!instr_valid && !host_en))
		else $error("instruction or host access while result_valid is high");

	a_no_overlap: assert property (@(posedge sys_clk) disable iff (!rst_n)
		!(instr_valid && host_en))
		else $error("instr_valid and host_en high together");

	// result_valid exactly one cycle after issue
	a_valid_follows: assert property (@(posedge sys_clk) disable iff (!rst_n)
		instr_valid |=> result_valid)
		else $error("result_valid missing one cycle after issue");

	a_valid_caused: assert property (@(posedge sys_clk) disable iff (!rst_n)
		result_valid |-> $past(instr_valid))
		else $error("result_valid without an issued instruction");

	// write-back only in the cycle after an instruction
	a_wb_caused: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(wb_en && !wb_nwe) |-> $past(instr_valid))
		else $error("port_a write without a preceding instruction");

endmodule

bind gpu_core gpu_core_assertions i_assertions (
	.sys_clk      (sys_clk),
	.rst_n        (rst_n),
	.instr_valid  (instr_valid),
	.host_en      (host_en),
	.result_valid (result_valid),
	.wb_en        (port_a.en),
	.wb_nwe       (port_a.nwe)
);

`default_nettype wire

//--- dv/gpu_core_tb.sv
// gpu core testbench with LCG random stimulus checked against a register and flag model
`default_nettype none

module gpu_core_tb;

	logic        sys_clk;
	logic        rst_n;
	logic        instr_valid;
	logic [15:0] instr;
	logic        host_en;
	logic        host_nwe;
	logic [5:0]  host_addr;
	logic [31:0] host_wdata;
	logic [31:0] host_rdata;
	logic        result_valid;
	logic [31:0] result;
	logic        z_flag;
	logic        c_flag;

	// reference state
	logic [31:0] model_mem [0:63];
	logic        model_bank;
	logic        model_z;
	logic        model_c;

	logic [31:0] rand_state;
	int          tests;
	int          checks;
	int          errors;
	int          test_err0;

	gpu_core i_dut (
		.sys_clk      (sys_clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.host_en      (host_en),
		.host_nwe     (host_nwe),
		.host_addr    (host_addr),
		.host_wdata   (host_wdata),
		.host_rdata   (host_rdata),
		.result_valid (result_valid),
		.result       (result),
		.z_flag       (z_flag),
		.c_flag       (c_flag)
	);

	always #20 sys_clk = ~sys_clk;

	function automatic logic [31:0] lcg_next();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	function automatic logic [15:0] reg_instr(input logic [5:0] op, input logic [4:0] src,
		input logic [4:0] dst);
		gpu_pkg::gpu_instr_u iw;
		iw.r.opcode = op;
		iw.r.src    = src;
		iw.r.dst    = dst;
		return iw;
	endfunction

	function automatic logic [15:0] quick_instr(input logic [5:0] op, input logic [4:0] imm,
		input logic [4:0] dst);
		gpu_pkg::gpu_instr_u iw;
		iw.q.opcode = op;
		iw.q.imm    = imm;
		iw.q.dst    = dst;
		return iw;
	endfunction

	function automatic logic [5:0] pick_two_op(input logic [31:0] r);
		case (r % 32'd7)
			32'd0:   return gpu_pkg::op_add;
			32'd1:   return gpu_pkg::op_sub;
			32'd2:   return gpu_pkg::op_and;
			32'd3:   return gpu_pkg::op_or;
			32'd4:   return gpu_pkg::op_xor;
			32'd5:   return gpu_pkg::op_move;
			default: return gpu_pkg::op_not;
		endcase
	endfunction

	// applies one instruction to the model and marks an undefined result through known
	function automatic void model_exec(input logic [15:0] word, output logic [31:0] y,
		output logic known);
		gpu_pkg::gpu_instr_u iw;
		logic [31:0] a;
		logic [31:0] b;
		logic [5:0]  n;
		logic [63:0] wide;
		logic        c;
		logic        wr;
		logic        fl;
		iw    = word;
		a     = model_mem[{model_bank, iw.r.dst}];
		b     = model_mem[{model_bank, iw.r.src}];
		n     = (iw.q.imm == 5'd0) ? 6'd32 : {1'b0, iw.q.imm};
		y     = '0;
		c     = 1'b0;
		wr    = 1'b1;
		fl    = 1'b1;
		known = 1'b1;
		case (iw.r.opcode)
			gpu_pkg::op_add:   {c, y} = {1'b0, a} + {1'b0, b};
			gpu_pkg::op_sub:   begin
				y = a - b;
				c = (a < b);
			end
			gpu_pkg::op_cmp:   begin
				y  = a - b;
				c  = (a < b);
				wr = 1'b0;
			end
			gpu_pkg::op_and:   y = a & b;
			gpu_pkg::op_or:    y = a | b;
			gpu_pkg::op_xor:   y = a ^ b;
			gpu_pkg::op_not:   y = ~a;
			gpu_pkg::op_move:  begin
				y  = b;
				fl = 1'b0;
			end
			gpu_pkg::op_moveq: begin
				y  = {27'd0, iw.q.imm};
				fl = 1'b0;
			end
			gpu_pkg::op_addq:  {c, y} = {1'b0, a} + {27'd0, n};
			gpu_pkg::op_shlq:  begin
				wide = {32'd0, a} << n;
				y    = wide[31:0];
				c    = wide[32];
			end
			gpu_pkg::op_shrq:  begin
				wide = {a, 32'd0} >> n;
				y    = wide[63:32];
				c    = wide[31];
			end
			gpu_pkg::op_bank:  begin
				wr         = 1'b0;
				fl         = 1'b0;
				known      = 1'b0;
				model_bank = iw.q.imm[0];
			end
			default: begin
				wr    = 1'b0;
				fl    = 1'b0;
				known = 1'b0;
			end
		endcase
		if (wr) begin
			model_mem[{model_bank, iw.r.dst}] = y;
		end
		if (fl) begin
			model_z = (y == 32'd0);
			model_c = c;
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("FAIL time %0t %s got %08h expected %08h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic host_write(input logic [5:0] addr, input logic [31:0] data);
		@(posedge sys_clk);
		host_en    <= 1'b1;
		host_nwe   <= 1'b0;
		host_addr  <= addr;
		host_wdata <= data;
		@(posedge sys_clk);
		host_en  <= 1'b0;
		host_nwe <= 1'b1;
		model_mem[addr] = data;
	endtask

	task automatic host_read_check(input logic [5:0] addr);
		@(posedge sys_clk);
		host_en   <= 1'b1;
		host_nwe  <= 1'b1;
		host_addr <= addr;
		@(posedge sys_clk);
		host_en <= 1'b0;
		@(negedge sys_clk);
		check_value($sformatf("host_rdata[%0d]", addr), host_rdata, model_mem[addr]);
	endtask

	// returns in the result cycle, so a following call issues every second cycle
	task automatic issue(input logic [15:0] word);
		int          wait_cnt;
		logic [31:0] exp_y;
		logic        known;
		model_exec(word, exp_y, known);
		@(posedge sys_clk);
		instr_valid <= 1'b1;
		instr       <= word;
		@(posedge sys_clk);
		instr_valid <= 1'b0;
		wait_cnt = 0;
		@(negedge sys_clk);
		while (!result_valid && wait_cnt < 8) begin
			@(negedge sys_clk);
			wait_cnt++;
		end
		if (!result_valid) begin
			$display("timeout waiting for result_valid after instruction %04h", word);
			$display("=== FAIL ===");
			$finish;
		end else if (known) begin
			check_value("result", result, exp_y);
		end
	endtask

	task automatic check_flags();
		@(posedge sys_clk);
		@(negedge sys_clk);
		check_value("z_flag", {31'd0, z_flag}, {31'd0, model_z});
		check_value("c_flag", {31'd0, c_flag}, {31'd0, model_c});
	endtask

	task automatic read_all();
		for (int i = 0; i < 64; i++) begin
			host_read_check(i[5:0]);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s: %s, %0d errors", tests, name,
			(errors == test_err0) ? "ok" : "failed", errors - test_err0);
		test_err0 = errors;
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] v;
		logic [4:0]  d;
		logic [4:0]  s;
		sys_clk     = 1'b0;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		host_en     = 1'b0;
		host_nwe    = 1'b1;
		host_addr   = '0;
		host_wdata  = '0;
		rand_state  = 32'hdf1440b7;
		model_bank  = 1'b0;
		model_z     = 1'b0;
		model_c     = 1'b0;
		tests       = 0;
		checks      = 0;
		errors      = 0;
		test_err0   = 0;
		repeat (16) @(posedge sys_clk);
		rst_n <= 1'b1;
		@(negedge sys_clk);

		// reset state, then host load of every word
		check_value("result_valid", {31'd0, result_valid}, 32'd0);
		check_value("z_flag", {31'd0, z_flag}, 32'd0);
		check_value("c_flag", {31'd0, c_flag}, 32'd0);
		for (int i = 0; i < 64; i++) begin
			host_write(i[5:0], lcg_next());
		end
		read_all();
		end_test("reset and host access");

		for (int i = 0; i < 40; i++) begin
			r = lcg_next();
			if (r[1:0] == 2'd0) begin
				issue(quick_instr(gpu_pkg::op_bank, {4'd0, r[2]}, 5'd0));
			end
			r = lcg_next();
			issue(reg_instr(pick_two_op(r), r[12:8], r[20:16]));
			check_flags();
			host_read_check({model_bank, r[20:16]});
		end
		end_test("two-operand ops");

		for (int i = 0; i < 40; i++) begin
			r = lcg_next();
			s = (i % 4 == 0) ? 5'd0 : r[12:8];
			case (r[25:24])
				2'd0:    issue(quick_instr(gpu_pkg::op_moveq, s, r[20:16]));
				2'd1:    issue(quick_instr(gpu_pkg::op_addq, s, r[20:16]));
				2'd2:    issue(quick_instr(gpu_pkg::op_shlq, s, r[20:16]));
				default: issue(quick_instr(gpu_pkg::op_shrq, s, r[20:16]));
			endcase
			check_flags();
			host_read_check({model_bank, r[20:16]});
		end
		end_test("quick ops");

		for (int i = 0; i < 24; i++) begin
			r = lcg_next();
			d = r[4:0];
			s = d ^ 5'd1;
			v = lcg_next();
			host_write({model_bank, d}, v);
			// equal operands, a below b, or random
			case (i % 3)
				0:       host_write({model_bank, s}, v);
				1:       host_write({model_bank, s}, v | 32'h8000_0000);
				default: host_write({model_bank, s}, lcg_next());
			endcase
			issue(reg_instr(r[8] ? gpu_pkg::op_cmp : gpu_pkg::op_sub, s, d));
			check_flags();
			host_read_check({model_bank, d});
			case (r[11:10])
				2'd0:    issue(reg_instr(gpu_pkg::op_move, r[16:12], r[21:17]));
				2'd1:    issue(quick_instr(gpu_pkg::op_moveq, r[16:12], r[21:17]));
				2'd2:    issue(quick_instr(gpu_pkg::op_bank, r[16:12], r[21:17]));
				default: issue(reg_instr(6'd63 - {4'd0, r[23:22]}, r[16:12], r[21:17]));
			endcase
			check_flags();
		end
		end_test("flags");

		for (int i = 0; i < 8; i++) begin
			r = lcg_next();
			issue(quick_instr(gpu_pkg::op_bank, {4'd0, r[0]}, 5'd0));
			issue(quick_instr(gpu_pkg::op_moveq, r[12:8], r[20:16]));
			issue(reg_instr(gpu_pkg::op_add, r[28:24], r[20:16]));
		end
		check_flags();
		read_all();
		end_test("bank switch");

		r = lcg_next();
		d = r[4:0];
		for (int i = 0; i < 20; i++) begin
			r = lcg_next();
			issue(reg_instr(pick_two_op(r), d, r[20:16]));
			d = r[20:16];
		end
		check_flags();
		read_all();
		end_test("back-to-back dependency");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/gpu_alu.sv
// combinational 32-bit ALU with add, sub, logic and shift ops plus zero and carry outputs
`default_nettype none

module gpu_alu (
	input  gpu_pkg::alu_op_e            op,
	input  logic [gpu_pkg::data_w-1:0]  a,
	input  logic [gpu_pkg::data_w-1:0]  b,
	input  logic [5:0]                  shamt,
	output logic [gpu_pkg::data_w-1:0]  y,
	output logic                        zero,
	output logic                        carry
);

	localparam int w = gpu_pkg::data_w;

	logic [w:0] sum;
	logic [w:0] diff;
	logic [w:0] shl_ext;
	logic [w:0] shr_ext;

	// one spare bit each for carry and borrow
	assign sum  = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	// extra bit catches the last bit shifted out, 0 when shamt is 0
	assign shl_ext = {1'b0, a} << shamt;
	assign shr_ext = {a, 1'b0} >> shamt;

	always_comb begin
		y     = '0;
		carry = 1'b0;
		case (op)
			gpu_pkg::alu_add: begin
				y     = sum[w-1:0];
				carry = sum[w];
			end
			gpu_pkg::alu_sub: begin
				y     = diff[w-1:0];
				// borrow, a below b
				carry = diff[w];
			end
			gpu_pkg::alu_and: begin
				y = a & b;
			end
			gpu_pkg::alu_or: begin
				y = a | b;
			end
			gpu_pkg::alu_xor: begin
				y = a ^ b;
			end
			gpu_pkg::alu_pass_b: begin
				y = b;
			end
			gpu_pkg::alu_not_a: begin
				y = ~a;
			end
			gpu_pkg::alu_shl: begin
				y     = shl_ext[w-1:0];
				carry = shl_ext[w];
			end
			gpu_pkg::alu_shr: begin
				y     = shr_ext[w:1];
				carry = shr_ext[0];
			end
			default: begin
				y     = '0;
				carry = 1'b0;
			end
		endcase
	end

	assign zero = (y == '0);

endmodule

`default_nettype wire

//--- hw/gpu_core.sv
// execution core top joining exec unit, ALU and register RAM behind plain ports
`default_nettype none

module gpu_core (
	input  logic                        sys_clk,
	input  logic                        rst_n,
	input  logic                        instr_valid,
	input  logic [15:0]                 instr,
	input  logic                        host_en,
	input  logic                        host_nwe,
	input  logic [gpu_pkg::addr_w-1:0]  host_addr,
	input  logic [gpu_pkg::data_w-1:0]  host_wdata,
	output logic [gpu_pkg::data_w-1:0]  host_rdata,
	output logic                        result_valid,
	output logic [gpu_pkg::data_w-1:0]  result,
	output logic                        z_flag,
	output logic                        c_flag
);

	gpu_ram_port_if port_a ();
	gpu_ram_port_if port_b ();

	gpu_pkg::alu_op_e            alu_op;
	logic [gpu_pkg::data_w-1:0]  alu_a;
	logic [gpu_pkg::data_w-1:0]  alu_b;
	logic [5:0]                  alu_shamt;
	logic [gpu_pkg::data_w-1:0]  alu_y;
	logic                        alu_zero;
	logic                        alu_carry;
	gpu_pkg::gpu_instr_u         instr_w;

	assign instr_w = instr;

	gpu_exec i_exec (
		.sys_clk      (sys_clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.instr        (instr_w),
		.host_en      (host_en),
		.host_nwe     (host_nwe),
		.host_addr    (host_addr),
		.host_wdata   (host_wdata),
		.port_a       (port_a.master),
		.port_b       (port_b.master),
		.alu_op       (alu_op),
		.alu_a        (alu_a),
		.alu_b        (alu_b),
		.alu_shamt    (alu_shamt),
		.alu_y        (alu_y),
		.alu_zero     (alu_zero),
		.alu_carry    (alu_carry),
		.result_valid (result_valid),
		.result       (result),
		.z_flag       (z_flag),
		.c_flag       (c_flag)
	);

	gpu_alu i_alu (
		.op    (alu_op),
		.a     (alu_a),
		.b     (alu_b),
		.shamt (alu_shamt),
		.y     (alu_y),
		.zero  (alu_zero),
		.carry (alu_carry)
	);

	gpu_regfile i_regfile (
		.sys_clk (sys_clk),
		.port_a  (port_a.ram),
		.port_b  (port_b.ram)
	);

	// host reads share port_b
	assign host_rdata = port_b.rdata;

endmodule

`default_nettype wire

//--- hw/gpu_exec.sv
// execute unit with instruction decode, bank select, RAM port muxing, write-back and flags
`default_nettype none

module gpu_exec (
	input  logic                        sys_clk,
	input  logic                        rst_n,
	input  logic                        instr_valid,
	input  gpu_pkg::gpu_instr_u         instr,
	input  logic                        host_en,
	input  logic                        host_nwe,
	input  logic [gpu_pkg::addr_w-1:0]  host_addr,
	input  logic [gpu_pkg::data_w-1:0]  host_wdata,
	gpu_ram_port_if.master              port_a,
	gpu_ram_port_if.master              port_b,
	output gpu_pkg::alu_op_e            alu_op,
	output logic [gpu_pkg::data_w-1:0]  alu_a,
	output logic [gpu_pkg::data_w-1:0]  alu_b,
	output logic [5:0]                  alu_shamt,
	input  logic [gpu_pkg::data_w-1:0]  alu_y,
	input  logic                        alu_zero,
	input  logic                        alu_carry,
	output logic                        result_valid,
	output logic [gpu_pkg::data_w-1:0]  result,
	output logic                        z_flag,
	output logic                        c_flag
);

	gpu_pkg::gpu_instr_u instr_q;
	logic                valid_q;
	logic                bank_q;

	// decode of the registered instruction
	logic       dec_wr;
	logic       dec_flags;
	logic       dec_quick;
	logic       dec_expand;
	logic       dec_bank;
	logic [5:0] imm_ext;

	always_comb begin
		alu_op     = gpu_pkg::alu_add;
		dec_wr     = 1'b0;
		dec_flags  = 1'b0;
		dec_quick  = 1'b0;
		dec_expand = 1'b0;
		dec_bank   = 1'b0;
		case (instr_q.r.opcode)
			gpu_pkg::op_add: begin
				dec_wr    = 1'b1;
				dec_flags = 1'b1;
			end
			gpu_pkg::op_sub: begin
				alu_op    = gpu_pkg::alu_sub;
				dec_wr    = 1'b1;
				dec_flags = 1'b1;
			end
			gpu_pkg::op_and: begin
				alu_op    = gpu_pkg::alu_and;
				dec_wr    = 1'b1;
				dec_flags = 1'b1;
			end
			gpu_pkg::op_or: begin
				alu_op    = gpu_pkg::alu_or;
				dec_wr    = 1'b1;
				dec_flags = 1'b1;
			end
			gpu_pkg::op_xor: begin
				alu_op    = gpu_pkg::alu_xor;
				dec_wr    = 1'b1;
				dec_flags = 1'b1;
			end
			gpu_pkg::op_not: begin
				alu_op    = gpu_pkg::alu_not_a;
				dec_wr    = 1'b1;
				dec_flags = 1'b1;
			end
			gpu_pkg::op_move: begin
				alu_op = gpu_pkg::alu_pass_b;
				dec_wr = 1'b1;
			end
			gpu_pkg::op_cmp: begin
				// flags only
				alu_op    = gpu_pkg::alu_sub;
				dec_flags = 1'b1;
			end
			gpu_pkg::op_moveq: begin
				alu_op    = gpu_pkg::alu_pass_b;
				dec_wr    = 1'b1;
				dec_quick = 1'b1;
			end
			gpu_pkg::op_addq: begin
				dec_wr     = 1'b1;
				dec_flags  = 1'b1;
				dec_quick  = 1'b1;
				dec_expand = 1'b1;
			end
			gpu_pkg::op_shlq: begin
				alu_op     = gpu_pkg::alu_shl;
				dec_wr     = 1'b1;
				dec_flags  = 1'b1;
				dec_quick  = 1'b1;
				dec_expand = 1'b1;
			end
			gpu_pkg::op_shrq: begin
				alu_op     = gpu_pkg::alu_shr;
				dec_wr     = 1'b1;
				dec_flags  = 1'b1;
				dec_quick  = 1'b1;
				dec_expand = 1'b1;
			end
			gpu_pkg::op_bank: begin
				dec_bank = 1'b1;
			end
			default: begin
				dec_wr = 1'b0;
			end
		endcase
	end

	// imm of 0 stands for 32 on addq and shifts
	assign imm_ext = (dec_expand && instr_q.q.imm == '0) ? 6'd32 : {1'b0, instr_q.q.imm};

	assign alu_a     = port_a.rdata;
	assign alu_b     = dec_quick ? {{(gpu_pkg::data_w-6){1'b0}}, imm_ext} : port_b.rdata;
	assign alu_shamt = imm_ext;

	assign result_valid = valid_q;
	assign result       = alu_y;

	// port_a reads dst at issue, writes it back in the following cycle
	always_comb begin
		if (valid_q) begin
			port_a.en   = dec_wr;
			port_a.nwe  = 1'b0;
			port_a.addr = {bank_q, instr_q.r.dst};
		end else begin
			port_a.en   = instr_valid;
			port_a.nwe  = 1'b1;
			port_a.addr = {bank_q, instr.r.dst};
		end
	end
	assign port_a.wdata = alu_y;

	// host owns port_b when it strobes
	always_comb begin
		if (host_en) begin
			port_b.en   = 1'b1;
			port_b.nwe  = host_nwe;
			port_b.addr = host_addr;
		end else begin
			port_b.en   = instr_valid;
			port_b.nwe  = 1'b1;
			port_b.addr = {bank_q, instr.r.src};
		end
	end
	assign port_b.wdata = host_wdata;

	// instruction word is payload
	always_ff @(posedge sys_clk) begin
		if (instr_valid) begin
			instr_q <= instr;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			bank_q  <= 1'b0;
			z_flag  <= 1'b0;
			c_flag  <= 1'b0;
		end else begin
			valid_q <= instr_valid;
			if (valid_q && dec_bank) begin
				bank_q <= instr_q.q.imm[0];
			end
			if (valid_q && dec_flags) begin
				z_flag <= alu_zero;
				c_flag <= alu_carry;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/gpu_pkg.sv
// gpu execution core package with RAM geometry, opcodes, ALU codes and instruction views
`default_nettype none

package gpu_pkg;

	// register RAM geometry, two banks of 32 registers
	localparam int addr_w = 6;
	localparam int data_w = 32;
	localparam int reg_w  = 5;

	// two-operand forms, dst = dst op src
	localparam logic [5:0] op_add   = 6'd0;
	localparam logic [5:0] op_sub   = 6'd4;
	localparam logic [5:0] op_and   = 6'd8;
	localparam logic [5:0] op_or    = 6'd10;
	localparam logic [5:0] op_xor   = 6'd11;
	localparam logic [5:0] op_not   = 6'd12;
	localparam logic [5:0] op_cmp   = 6'd30;
	localparam logic [5:0] op_move  = 6'd34;

	// quick forms, src field holds an immediate
	localparam logic [5:0] op_addq  = 6'd2;
	localparam logic [5:0] op_shlq  = 6'd24;
	localparam logic [5:0] op_shrq  = 6'd25;
	localparam logic [5:0] op_moveq = 6'd35;
	localparam logic [5:0] op_bank  = 6'd40;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass_b,
		alu_not_a,
		alu_shl,
		alu_shr
	} alu_op_e;

	// register view
	typedef struct packed {
		logic [5:0]       opcode;
		logic [reg_w-1:0] src;
		logic [reg_w-1:0] dst;
	} gpu_instr_reg_t;

	// quick view, same bits read as an immediate
	typedef struct packed {
		logic [5:0]       opcode;
		logic [reg_w-1:0] imm;
		logic [reg_w-1:0] dst;
	} gpu_instr_quick_t;

	typedef union packed {
		gpu_instr_reg_t   r;
		gpu_instr_quick_t q;
	} gpu_instr_u;

endpackage

`default_nettype wire

//--- hw/gpu_ram_port_if.sv
// register RAM port bundle with strobe, active-low write, address and data
`default_nettype none

interface gpu_ram_port_if;

	// strobe and active-low write enable
	logic en;
	logic nwe;
	logic [gpu_pkg::addr_w-1:0] addr;
	logic [gpu_pkg::data_w-1:0] wdata;
	// registered read data, one cycle behind addr
	logic [gpu_pkg::data_w-1:0] rdata;

	modport master (
		output en,
		output nwe,
		output addr,
		output wdata,
		input  rdata
	);

	modport ram (
		input  en,
		input  nwe,
		input  addr,
		input  wdata,
		output rdata
	);

endinterface

`default_nettype wire

//--- hw/gpu_regfile.sv
// 64x32 two-port register RAM with strobed active-low writes and old-data registered reads
`default_nettype none

module gpu_regfile (
	input  logic           sys_clk,
	gpu_ram_port_if.ram    port_a,
	gpu_ram_port_if.ram    port_b
);

	localparam int depth = 1 << gpu_pkg::addr_w;

	logic [gpu_pkg::data_w-1:0] ram_blk [0:depth-1];
	logic [gpu_pkg::data_w-1:0] q_a;
	logic [gpu_pkg::data_w-1:0] q_b;

	logic wr_a;
	logic wr_b;

	assign wr_a = port_a.en & ~port_a.nwe;
	assign wr_b = port_b.en & ~port_b.nwe;

	// writes on either strobed port
	always_ff @(posedge sys_clk) begin
		if (wr_a) begin
			ram_blk[port_a.addr] <= port_a.wdata;
		end
		if (wr_b) begin
			ram_blk[port_b.addr] <= port_b.wdata;
		end
	end

	// reads sample the array before this edge's writes land,
	// so a same-address write on the other port returns old data
	always_ff @(posedge sys_clk) begin
		q_a <= ram_blk[port_a.addr];
		q_b <= ram_blk[port_b.addr];
	end

	assign port_a.rdata = q_a;
	assign port_b.rdata = q_b;

endmodule

`default_nettype wire

//--- project.f
hw/gpu_pkg.sv
hw/gpu_ram_port_if.sv
hw/gpu_regfile.sv
hw/gpu_alu.sv
hw/gpu_exec.sv
hw/gpu_core.sv
dv/gpu_core_assertions.sv
dv/gpu_core_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the gpu core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module gpu_core_tb \
	-f project.f -o gpu_core_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/gpu_core_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
